// ==== common/cart_consts.svh ====
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// Host side byte address and word width
`define CART_ADDR_W 25
`define CART_DATA_W 16

// Cartridge header offsets
`define CART_HDR_REGION_A 25'h1F0
`define CART_HDR_REGION_B 25'h1F2
`define CART_HDR_END      25'h200
`define CART_ID_FIRST     25'h182
`define CART_ID_MATCH     25'h18C
`define CART_ID_W         64

// Product ID table, codes use the cart_pkg quirk names
`define CART_QUIRK_N 13
`define CART_QUIRK_IDS '{"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", \
	"T-113016", "T-89016 ", "T-574023", "T-574013", "MK-1229 ", "G-7001  ", \
	"T-35036 ", "T-25073 ", "T-68???-"}
`define CART_QUIRK_CODES '{SRAM, SRAM, EEPROM, EEPROM, NORAM, FIFO, PIER, PIER, \
	SVP, SVP, FMBUSY, FMBUSY, SCHAN}

`endif

// ==== common/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

	// Console region, also used as a bit index into the letter flags
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Region priority orders, highest first
	typedef enum logic [1:0] {
		US_EU_JP = 2'd0,
		EU_US_JP = 2'd1,
		US_JP_EU = 2'd2,
		JP_US_EU = 2'd3
	} region_order_t;

	// Per-title compatibility quirk
	typedef enum logic [3:0] {
		NONE   = 4'd0,
		SRAM   = 4'd1,
		EEPROM = 4'd2,
		NORAM  = 4'd3,
		FIFO   = 4'd4,
		PIER   = 4'd5,
		SVP    = 4'd6,
		FMBUSY = 4'd7,
		SCHAN  = 4'd8
	} quirk_t;

	// ROM write handshake
	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		REQ     = 2'd1,
		RELEASE = 2'd2
	} wr_state_t;

endpackage

`default_nettype wire

// ==== hw/load_capture.sv ====
`default_nettype none
`include "cart_consts.svh"

module load_capture (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    load_active,
	input  logic                    load_wr,
	input  logic [`CART_ADDR_W-1:0] load_addr,
	input  logic [`CART_DATA_W-1:0] load_data,
	input  logic                    word_done,
	output logic                    word_valid,
	output logic [`CART_ADDR_W-1:0] word_addr,
	output logic [`CART_DATA_W-1:0] word_data,
	output logic                    load_start,
	output logic                    load_end,
	output logic                    load_wait,
	output logic [`CART_ADDR_W-1:0] rom_size
);

	logic active_q;
	logic accept;

	// One word in flight, so nothing is taken while waiting
	assign accept = load_active && load_wr && !load_wait;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			active_q   <= 1'b0;
			load_start <= 1'b0;
			load_end   <= 1'b0;
			word_valid <= 1'b0;
			load_wait  <= 1'b0;
			rom_size   <= '0;
		end else begin
			active_q   <= load_active;
			load_start <= load_active && !active_q;
			load_end   <= !load_active && active_q;
			word_valid <= accept;
			if (accept)
				load_wait <= 1'b1;
			else if (word_done)
				load_wait <= 1'b0;
			// word_addr still holds the last accepted address here
			if (load_end)
				rom_size <= word_addr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			word_addr <= load_addr;
			word_data <= load_data;
		end
	end

endmodule

`default_nettype wire

// ==== header/region_scan.sv ====
`default_nettype none
`include "cart_consts.svh"

module region_scan (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    word_valid,
	input  logic [`CART_ADDR_W-1:0] word_addr,
	input  logic [`CART_DATA_W-1:0] word_data,
	input  logic                    load_start,
	input  cart_pkg::region_order_t region_order,
	output cart_pkg::region_t       region,
	output logic                    region_valid
);

	import cart_pkg::*;

	// Flags indexed by region_t
	logic [2:0] seen;
	logic [2:0] hit;

	function automatic logic [2:0] classify(input logic [7:0] c);
		logic [2:0] mask;
		mask = 3'b000;
		if (c == "J")
			mask[JP] = 1'b1;
		else if (c == "U")
			mask[US] = 1'b1;
		else if (c >= "0" && c <= "Z")
			mask[EU] = 1'b1;
		return mask;
	endfunction

	function automatic region_t resolve(input region_order_t ord, input logic [2:0] flags);
		region_t first;
		region_t second;
		region_t third;
		case (ord)
			EU_US_JP: begin
				first  = EU;
				second = US;
				third  = JP;
			end
			US_JP_EU: begin
				first  = US;
				second = JP;
				third  = EU;
			end
			JP_US_EU: begin
				first  = JP;
				second = US;
				third  = EU;
			end
			default: begin
				first  = US;
				second = EU;
				third  = JP;
			end
		endcase
		// No letters at all falls back to the top of the order
		if (flags[second] && !flags[first])
			return second;
		if (flags[third] && !flags[first] && !flags[second])
			return third;
		return first;
	endfunction

	// Second region word only carries a letter in its low byte
	always_comb begin
		hit = 3'b000;
		if (word_addr == `CART_HDR_REGION_A)
			hit = classify(word_data[7:0]) | classify(word_data[15:8]);
		else if (word_addr == `CART_HDR_REGION_B)
			hit = classify(word_data[7:0]);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			seen         <= 3'b000;
			region       <= JP;
			region_valid <= 1'b0;
		end else if (load_start) begin
			seen         <= 3'b000;
			region_valid <= 1'b0;
		end else if (word_valid) begin
			seen <= seen | hit;
			if (word_addr == `CART_HDR_END) begin
				region       <= resolve(region_order, seen);
				region_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== header/quirk_match.sv ====
`default_nettype none
`include "cart_consts.svh"

module quirk_match (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    word_valid,
	input  logic [`CART_ADDR_W-1:0] word_addr,
	input  logic [`CART_DATA_W-1:0] word_data,
	input  logic                    load_start,
	output cart_pkg::quirk_t        quirk
);

	import cart_pkg::*;

	localparam logic [`CART_ID_W-1:0] quirk_ids [`CART_QUIRK_N] = `CART_QUIRK_IDS;
	localparam quirk_t quirk_codes [`CART_QUIRK_N] = `CART_QUIRK_CODES;

	logic [`CART_ID_W-1:0] cart_id;

	// IDs in the table are unique, so at most one entry hits
	function automatic quirk_t lookup(input logic [`CART_ID_W-1:0] id);
		quirk_t q;
		q = NONE;
		for (int i = 0; i < `CART_QUIRK_N; i++) begin
			if (id == quirk_ids[i])
				q = quirk_codes[i];
		end
		return q;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Product ID assembly
	//////////////////////////////////////////////////////////////////////

	// Header words arrive byte swapped, first and last word are half used
	always_ff @(posedge clk_sys) begin
		if (word_valid) begin
			case (word_addr)
				`CART_ID_FIRST:
					cart_id[63:56] <= word_data[15:8];
				`CART_ID_FIRST + 25'h2:
					cart_id[55:40] <= {word_data[7:0], word_data[15:8]};
				`CART_ID_FIRST + 25'h4:
					cart_id[39:24] <= {word_data[7:0], word_data[15:8]};
				`CART_ID_FIRST + 25'h6:
					cart_id[23:8] <= {word_data[7:0], word_data[15:8]};
				`CART_ID_FIRST + 25'h8:
					cart_id[7:0] <= word_data[7:0];
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Table lookup
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET || load_start)
			quirk <= NONE;
		else if (word_valid && word_addr == `CART_ID_MATCH)
			quirk <= lookup(cart_id);
	end

endmodule

`default_nettype wire

// ==== hw/rom_write_port.sv ====
`default_nettype none
`include "cart_consts.svh"

module rom_write_port (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    word_valid,
	input  logic [`CART_ADDR_W-1:0] word_addr,
	input  logic [`CART_DATA_W-1:0] word_data,
	input  logic                    mem_ack,
	output logic                    mem_req,
	output logic [`CART_ADDR_W-2:0] mem_addr,
	output logic [`CART_DATA_W-1:0] mem_data,
	output logic                    word_done
);

	import cart_pkg::*;

	wr_state_t state;

	// Four-phase handshake, done only after ack has dropped
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state     <= IDLE;
			word_done <= 1'b0;
		end else begin
			word_done <= 1'b0;
			case (state)
				IDLE:
					if (word_valid)
						state <= REQ;
				REQ:
					if (mem_ack)
						state <= RELEASE;
				RELEASE:
					if (!mem_ack) begin
						state     <= IDLE;
						word_done <= 1'b1;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Word address and swapped bytes for the memory
	always_ff @(posedge clk_sys) begin
		if (state == IDLE && word_valid) begin
			mem_addr <= word_addr[`CART_ADDR_W-1:1];
			mem_data <= {word_data[7:0], word_data[15:8]};
		end
	end

	assign mem_req = (state == REQ);

endmodule

`default_nettype wire

// ==== hw/cart_loader.sv ====
`default_nettype none
`include "cart_consts.svh"

module cart_loader (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic                        load_active,
	input  logic                        load_wr,
	input  logic [`CART_ADDR_W-1:0]     load_addr,
	input  logic [`CART_DATA_W-1:0]     load_data,
	input  cart_pkg::region_order_t     region_order,
	input  logic                        mem_ack,
	output logic                        load_wait,
	output logic                        mem_req,
	output logic [`CART_ADDR_W-2:0]     mem_addr,
	output logic [`CART_DATA_W-1:0]     mem_data,
	output logic [`CART_ADDR_W-1:0]     rom_size,
	output cart_pkg::region_t           region,
	output logic                        region_valid,
	output cart_pkg::quirk_t            quirk
);

	logic                    word_valid;
	logic [`CART_ADDR_W-1:0] word_addr;
	logic [`CART_DATA_W-1:0] word_data;
	logic                    word_done;
	logic                    load_start;

	//////////////////////////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////////////////////////

	load_capture u_capture (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.load_active (load_active),
		.load_wr     (load_wr),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.word_done   (word_done),
		.word_valid  (word_valid),
		.word_addr   (word_addr),
		.word_data   (word_data),
		.load_start  (load_start),
		.load_end    (),
		.load_wait   (load_wait),
		.rom_size    (rom_size)
	);

	//////////////////////////////////////////////////////////////////////
	// Header snooping
	//////////////////////////////////////////////////////////////////////

	region_scan u_region (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.word_valid   (word_valid),
		.word_addr    (word_addr),
		.word_data    (word_data),
		.load_start   (load_start),
		.region_order (region_order),
		.region       (region),
		.region_valid (region_valid)
	);

	quirk_match u_quirk (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.word_valid (word_valid),
		.word_addr  (word_addr),
		.word_data  (word_data),
		.load_start (load_start),
		.quirk      (quirk)
	);

	//////////////////////////////////////////////////////////////////////
	// ROM memory side
	//////////////////////////////////////////////////////////////////////

	rom_write_port u_write (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.word_valid (word_valid),
		.word_addr  (word_addr),
		.word_data  (word_data),
		.mem_ack    (mem_ack),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.word_done  (word_done)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clk_sys
);
	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period, starts low
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

endmodule

`default_nettype wire

// ==== testbench/cart_checker.sv ====
`default_nettype none
`include "cart_consts.svh"

module cart_checker (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    load_active,
	input  logic                    load_wr,
	input  logic [`CART_ADDR_W-1:0] load_addr,
	input  logic [`CART_DATA_W-1:0] load_data,
	input  cart_pkg::region_order_t region_order,
	input  logic                    mem_ack,
	input  logic                    load_wait,
	input  logic                    mem_req,
	input  logic [`CART_ADDR_W-2:0] mem_addr,
	input  logic [`CART_DATA_W-1:0] mem_data,
	input  logic [`CART_ADDR_W-1:0] rom_size,
	input  cart_pkg::region_t       region,
	input  logic                    region_valid,
	input  cart_pkg::quirk_t        quirk,
	output int                      tests_run,
	output int                      tests_failed,
	output int                      errors
);
	timeunit 1ns;
	timeprecision 100ps;

	import cart_pkg::*;

	localparam logic [`CART_ID_W-1:0] table_ids [`CART_QUIRK_N] = `CART_QUIRK_IDS;
	localparam quirk_t table_codes [`CART_QUIRK_N] = `CART_QUIRK_CODES;

	// Expected memory writes with the word address above the swapped data
	logic [39:0]             pending [$];
	logic [7:0]              id_chars [8];
	logic [2:0]              flags = 3'b000;
	logic [`CART_ADDR_W-1:0] last_addr = '0;
	logic                    in_reset = 1'b0;
	logic                    prev_req = 1'b0;
	logic                    prev_ack = 1'b0;
	logic                    prev_active = 1'b0;
	logic                    wait_due = 1'b0;
	logic                    end_due = 1'b0;
	logic                    size_due = 1'b0;
	// Model outputs where nxt shows up one cycle after cur
	logic                    cur_valid = 1'b0;
	logic                    nxt_valid = 1'b0;
	region_t                 cur_region = JP;
	region_t                 nxt_region = JP;
	quirk_t                  cur_quirk = NONE;
	quirk_t                  nxt_quirk = NONE;
	int                      run_count = 0;
	int                      fail_count = 0;
	int                      error_count = 0;
	int                      test_errors = 0;
	int                      test_words = 0;

	assign tests_run    = run_count;
	assign tests_failed = fail_count;
	assign errors       = error_count;

	// Bit 0 JP, bit 1 US, bit 2 EU
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		if (c == "J")
			return 3'b001;
		if (c == "U")
			return 3'b010;
		if (c inside {["0":"Z"]})
			return 3'b100;
		return 3'b000;
	endfunction

	function automatic region_t pick_region(input region_order_t ord, input logic [2:0] f);
		region_t seq [3];
		region_t pick;
		logic    found;
		case (ord)
			US_EU_JP: seq = '{US, EU, JP};
			EU_US_JP: seq = '{EU, US, JP};
			US_JP_EU: seq = '{US, JP, EU};
			default:  seq = '{JP, US, EU};
		endcase
		pick  = seq[0];
		found = 1'b0;
		for (int i = 0; i < 3; i++) begin
			if (!found && f[seq[i]]) begin
				pick  = seq[i];
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	function automatic quirk_t find_quirk(input logic [63:0] key);
		quirk_t q;
		q = NONE;
		for (int i = 0; i < `CART_QUIRK_N; i++)
			if (table_ids[i] == key)
				q = table_codes[i];
		return q;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_fault(input string msg);
		$display("Error at %0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	task automatic finish_test(input string label);
		$display("test %0d %s: %s", run_count, label, test_errors == 0 ? "ok" : "FAILED");
		run_count++;
		if (test_errors != 0)
			fail_count++;
		test_errors = 0;
		test_words  = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sampled at the falling edge where all ports have settled
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin : watch
		logic [39:0] exp_word;
		int          m;
		if (RESET) begin
			in_reset = 1'b1;
			pending.delete();
			{prev_req, prev_ack, prev_active, wait_due, size_due, end_due} = 6'b0;
			{cur_valid, nxt_valid, flags} = 5'b0;
			cur_quirk = NONE;
			nxt_quirk = NONE;
		end else begin
			if (in_reset) begin
				in_reset = 1'b0;
				expect_equal("load_wait", 32'(load_wait), 32'd0);
				expect_equal("mem_req", 32'(mem_req), 32'd0);
				expect_equal("region_valid", 32'(region_valid), 32'd0);
				expect_equal("quirk", 32'(quirk), 32'(NONE));
				finish_test("reset");
			end
			if (wait_due)
				expect_equal("load_wait", 32'(load_wait), 32'd1);
			wait_due = 1'b0;
			expect_equal("region_valid", 32'(region_valid), 32'(cur_valid));
			if (cur_valid && region_valid)
				expect_equal("region", 32'(region), 32'(cur_region));
			expect_equal("quirk", 32'(quirk), 32'(cur_quirk));
			if (size_due) begin
				expect_equal("rom_size", 32'(rom_size), 32'(last_addr));
				if (pending.size() != 0)
					report_fault("load ended with words still waiting for the memory");
				finish_test($sformatf("load of %0d words, order %0d, region %s, quirk %s",
					test_words, region_order, cur_region.name(), cur_quirk.name()));
				size_due = 1'b0;
			end

			// Four-phase handshake and memory contents
			if (mem_req && !prev_req) begin
				if (prev_ack)
					report_fault("mem_req rose while mem_ack was still high");
				if (pending.size() == 0) begin
					report_fault("memory request with no word pending");
				end else begin
					exp_word = pending.pop_front();
					expect_equal("mem_addr", 32'(mem_addr), 32'(exp_word[39:16]));
					expect_equal("mem_data", 32'(mem_data), 32'(exp_word[15:0]));
					test_words++;
				end
			end
			if (!mem_req && prev_req && !prev_ack)
				report_fault("mem_req dropped before mem_ack rose");
			// A word is in flight until its handshake has fully completed
			if ((mem_req || mem_ack) && !load_wait)
				report_fault("load_wait was low while a memory write was in progress");

			cur_valid  = nxt_valid;
			cur_region = nxt_region;
			cur_quirk  = nxt_quirk;

			if (load_active && !prev_active) begin
				flags     = 3'b000;
				nxt_valid = 1'b0;
				nxt_quirk = NONE;
				test_errors = 0;
				test_words  = 0;
			end
			if (load_active && load_wr && !load_wait) begin
				pending.push_back({load_addr[`CART_ADDR_W-1:1], load_data[7:0], load_data[15:8]});
				wait_due  = 1'b1;
				last_addr = load_addr;
				if (load_addr == `CART_HDR_REGION_A)
					flags = flags | letter_flags(load_data[7:0]) | letter_flags(load_data[15:8]);
				if (load_addr == `CART_HDR_REGION_B)
					flags = flags | letter_flags(load_data[7:0]);
				// ID word m carries characters 2m-1 low and 2m high
				if (load_addr >= `CART_ID_FIRST && load_addr <= `CART_ID_FIRST + 25'h8) begin
					m = int'((load_addr - `CART_ID_FIRST) >> 1);
					if (m > 0)
						id_chars[2 * m - 1] = load_data[7:0];
					if (m < 4)
						id_chars[2 * m] = load_data[15:8];
				end
				if (load_addr == `CART_ID_MATCH)
					nxt_quirk = find_quirk({id_chars[0], id_chars[1], id_chars[2], id_chars[3],
						id_chars[4], id_chars[5], id_chars[6], id_chars[7]});
				if (load_addr == `CART_HDR_END) begin
					nxt_valid  = 1'b1;
					nxt_region = pick_region(region_order, flags);
				end
			end
			// rom_size is written on the load_end pulse after load_active falls
			size_due = end_due;
			end_due  = !load_active && prev_active;

			prev_req    = mem_req;
			prev_ack    = mem_ack;
			prev_active = load_active;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/cart_tb.sv ====
`default_nettype none
`include "cart_consts.svh"

module cart_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import cart_pkg::*;

	localparam int NUM_LOADS = 8;
	// Longest image is 257 header words plus up to 31 more
	localparam int MAX_WORDS = NUM_LOADS * (257 + 31);
	localparam int CYCLE_LIMIT = MAX_WORDS * 40 + 2000;

	localparam logic [`CART_ID_W-1:0] table_ids [`CART_QUIRK_N] = `CART_QUIRK_IDS;

	logic                    clk_sys;
	logic                    RESET;
	logic                    load_active;
	logic                    load_wr;
	logic [`CART_ADDR_W-1:0] load_addr;
	logic [`CART_DATA_W-1:0] load_data;
	region_order_t           region_order;
	logic                    mem_ack = 1'b0;
	logic                    load_wait;
	logic                    mem_req;
	logic [`CART_ADDR_W-2:0] mem_addr;
	logic [`CART_DATA_W-1:0] mem_data;
	logic [`CART_ADDR_W-1:0] rom_size;
	region_t                 region;
	logic                    region_valid;
	quirk_t                  quirk;
	int                      tests_run;
	int                      tests_failed;
	int                      errors;
	int                      cycles = 0;
	logic [31:0]             stim_lfsr = 32'hd8ca;
	logic [31:0]             ack_lfsr = 32'hd8ca;
	logic [2:0]              ack_delay = 3'd0;

	tb_clock clk0 (.clk_sys(clk_sys));

	cart_loader dut0 (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.load_active  (load_active),
		.load_wr      (load_wr),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.region_order (region_order),
		.mem_ack      (mem_ack),
		.load_wait    (load_wait),
		.mem_req      (mem_req),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.rom_size     (rom_size),
		.region       (region),
		.region_valid (region_valid),
		.quirk        (quirk)
	);

	cart_checker chk0 (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.load_active  (load_active),
		.load_wr      (load_wr),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.region_order (region_order),
		.mem_ack      (mem_ack),
		.load_wait    (load_wait),
		.mem_req      (mem_req),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.rom_size     (rom_size),
		.region       (region),
		.region_valid (region_valid),
		.quirk        (quirk),
		.tests_run    (tests_run),
		.tests_failed (tests_failed),
		.errors       (errors)
	);

	//////////////////////////////////////////////////////////////////////
	// Random numbers
	//////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(inout logic [31:0] state, input int count,
			output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			state = lfsr_step(state);
			value = {value[30:0], state[0]};
		end
	endtask

	// Region letters mixed with characters that must not count
	function automatic logic [7:0] pick_letter(input logic [2:0] k);
		case (k)
			3'd0: return "J";
			3'd1: return "U";
			3'd2: return "E";
			3'd3: return "A";
			3'd4: return "4";
			3'd5: return " ";
			3'd6: return "z";
			default: return 8'h00;
		endcase
	endfunction

	// Header words carry the ID one character per byte, as the cartridge lays it out
	function automatic logic [15:0] image_word(input logic [`CART_ADDR_W-1:0] addr,
			input logic [63:0] id, input logic [23:0] letters, input logic [15:0] fill);
		case (addr)
			`CART_ID_FIRST:         return {id[63:56], fill[7:0]};
			`CART_ID_FIRST + 25'h2: return {id[47:40], id[55:48]};
			`CART_ID_FIRST + 25'h4: return {id[31:24], id[39:32]};
			`CART_ID_FIRST + 25'h6: return {id[15:8], id[23:16]};
			`CART_ID_FIRST + 25'h8: return {fill[15:8], id[7:0]};
			`CART_HDR_REGION_A:     return letters[15:0];
			`CART_HDR_REGION_B:     return {fill[15:8], letters[23:16]};
			default:                return fill;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic write_word(input logic [`CART_ADDR_W-1:0] addr,
			input logic [`CART_DATA_W-1:0] data);
		while (load_wait)
			next_cycle();
		load_addr = addr;
		load_data = data;
		load_wr   = 1'b1;
		next_cycle();
		load_wr   = 1'b0;
	endtask

	// Even loads use a table title, odd loads a random ID
	task automatic load_image(input int idx);
		logic [31:0] r;
		logic [31:0] r2;
		logic [63:0] id;
		logic [23:0] letters;
		int          n_words;
		region_order = region_order_t'(idx[1:0]);
		take_bits(stim_lfsr, 5, r);
		n_words = 257 + int'(r[4:0]);
		if (idx[0] == 1'b0) begin
			take_bits(stim_lfsr, 4, r);
			id = table_ids[r % `CART_QUIRK_N];
		end else begin
			take_bits(stim_lfsr, 32, r);
			take_bits(stim_lfsr, 32, r2);
			id = {r, r2};
		end
		take_bits(stim_lfsr, 9, r);
		letters = {pick_letter(r[8:6]), pick_letter(r[5:3]), pick_letter(r[2:0])};
		load_active = 1'b1;
		repeat (2) next_cycle();
		for (int i = 0; i < n_words; i++) begin
			take_bits(stim_lfsr, 16, r);
			write_word(25'(2 * i), image_word(25'(2 * i), id, letters, r[15:0]));
		end
		while (load_wait)
			next_cycle();
		load_active = 1'b0;
		repeat (3) next_cycle();
	endtask

	// Memory answers each request after 0 to 7 cycles
	always @(posedge clk_sys) begin : responder
		logic [31:0] r;
		#2;
		if (RESET) begin
			mem_ack   = 1'b0;
			ack_delay = 3'd0;
		end else if (mem_req && !mem_ack) begin
			if (ack_delay == 3'd0)
				mem_ack = 1'b1;
			else
				ack_delay = ack_delay - 3'd1;
		end else if (!mem_req && mem_ack) begin
			mem_ack = 1'b0;
			take_bits(ack_lfsr, 3, r);
			ack_delay = r[2:0];
		end
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		RESET        = 1'b1;
		load_active  = 1'b0;
		load_wr      = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		region_order = US_EU_JP;
		repeat (2) @(posedge clk_sys);
		#2;
		RESET = 1'b0;
		repeat (4) next_cycle();
		for (int i = 0; i < NUM_LOADS; i++)
			load_image(i);
		repeat (4) next_cycle();
		if (tests_run != NUM_LOADS + 1)
			$display("Only %0d of %0d tests completed", tests_run, NUM_LOADS + 1);
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_run == NUM_LOADS + 1)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/cart_pkg.sv
hw/load_capture.sv
header/region_scan.sv
header/quirk_match.sv
hw/rom_write_port.sv
hw/cart_loader.sv
testbench/tb_clock.sv
testbench/cart_checker.sv
testbench/cart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cartridge loader testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module cart_tb -Mdir obj_dir &&
./obj_dir/Vcart_tb | tee /dev/stderr | grep -q "Verification passed" &&
echo "run_sim: simulation succeeded" ||
{ echo "run_sim: simulation did not succeed"; exit 1; }
